/* include/edge_defines.svh */
`ifndef EDGE_DEFINES_SVH
`define EDGE_DEFINES_SVH

//////////////////////////////////////////////////
// edge geometry
//////////////////////////////////////////////////

// one edge field as stored in memory
`define EDGE_BITS 32
`define EDGE_BYTES 4

//////////////////////////////////////////////////
// cacheline geometry
//////////////////////////////////////////////////

`define CACHELINE_BYTES 128
`define CACHELINE_BITS (`CACHELINE_BYTES * 8)
`define CACHELINE_EDGES (`CACHELINE_BYTES / `EDGE_BYTES)

// byte address on the memory side
`define ADDR_BITS 64

// queue depths
`define CMD_FIFO_DEPTH 4
`define EDGE_FIFO_DEPTH 64

`endif

/* logic/mem_cmd_pkg.sv */
package mem_cmd_pkg;

	`include "edge_defines.svh"

	// which edge array a command or response belongs to
	typedef enum logic [1:0] {
		SRC    = 2'd0,
		DEST   = 2'd1,
		WEIGHT = 2'd2
	} array_sel_t;

	// request size in bytes, always a power of two
	typedef logic [7:0] req_size_t;

	// edge offset or edge count inside one line
	typedef logic [5:0] line_idx_t;

	// smallest power of two bytes that covers count edges, one line at most
	function automatic req_size_t request_size(input line_idx_t count);
		req_size_t size;
		int        needed;
		size   = req_size_t'(`EDGE_BYTES);
		needed = int'(count) * `EDGE_BYTES;
		for (int i = 0; i < $clog2(`CACHELINE_EDGES); i++) begin
			if ((int'(size) < needed) && (int'(size) < `CACHELINE_BYTES)) begin
				size = size << 1;
			end
		end
		return size;
	endfunction

endpackage

/* logic/edge_job_pkg.sv */
package edge_job_pkg;

	`include "edge_defines.svh"

	// edge indices, degrees and running ids
	typedef logic [31:0] edge_count_t;

	// one src, dest or weight field
	typedef logic [`EDGE_BITS-1:0] edge_t;

	//////////////////////////////////////////////////
	// endianness
	//////////////////////////////////////////////////

	// memory holds edges in the opposite byte order
	function automatic edge_t swap_edge_bytes(input edge_t value);
		edge_t swapped;
		swapped = '0;
		for (int i = 0; i < `EDGE_BYTES; i++) begin
			swapped[i*8 +: 8] = value[(`EDGE_BYTES-1-i)*8 +: 8];
		end
		return swapped;
	endfunction

endpackage

/* logic/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 4
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         push,
	input  logic [WIDTH-1:0]             data_in,
	output logic                         full,
	output logic [$clog2(DEPTH+1)-1:0]   free_slots,
	input  logic                         pop,
	output logic                         valid,
	output logic [WIDTH-1:0]             data_out,
	output logic                         empty
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH+1);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	// overflow and underflow requests are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_BITS'(do_push) - CNT_BITS'(do_pop);
		end
	end

	// head shows without a pop, first word fall through
	assign data_out   = mem[rd_ptr];
	assign empty      = (count == '0);
	assign full       = (count == CNT_BITS'(DEPTH));
	assign valid      = !empty;
	assign free_slots = CNT_BITS'(DEPTH) - count;

endmodule

/* logic/edge_read_cmd_gen.sv */
`timescale 1ns/1ps

`include "edge_defines.svh"

module edge_read_cmd_gen (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        vertex_valid,
	input  edge_job_pkg::edge_count_t   vertex_id,
	input  edge_job_pkg::edge_count_t   vertex_edges_idx,
	input  edge_job_pkg::edge_count_t   vertex_degree,
	output logic                        vertex_pop,
	input  logic [`ADDR_BITS-1:0]       src_base,
	input  logic [`ADDR_BITS-1:0]       dest_base,
	input  logic [`ADDR_BITS-1:0]       weight_base,
	input  logic                        issue_ok,
	output logic                        cmd_push,
	output logic [`ADDR_BITS-1:0]       cmd_address,
	output mem_cmd_pkg::req_size_t      cmd_size,
	output mem_cmd_pkg::array_sel_t     cmd_array,
	output mem_cmd_pkg::line_idx_t      cmd_offset,
	output mem_cmd_pkg::line_idx_t      cmd_count,
	output edge_job_pkg::edge_count_t   cur_degree
);

	import mem_cmd_pkg::*;
	import edge_job_pkg::*;

	localparam int LINE_BITS  = $clog2(`CACHELINE_BYTES);
	localparam int EDGE_SHIFT = $clog2(`EDGE_BYTES);
	localparam int PAD_BITS   = `ADDR_BITS - $bits(edge_count_t);

	typedef enum logic [2:0] {
		ST_ACCEPT,
		ST_INIT,
		ST_WAIT,
		ST_CALC,
		ST_IDLE,
		ST_SRC,
		ST_DEST,
		ST_WEIGHT
	} state_t;

	state_t                state;
	state_t                next_state;
	edge_count_t           remaining;
	edge_count_t           last_id;
	logic                  have_last;
	logic                  new_job;
	logic [`ADDR_BITS-1:0] byte_off;
	logic [`ADDR_BITS-1:0] aligned;
	logic [`ADDR_BITS-1:0] base;
	line_idx_t             rem_edges;
	line_idx_t             span_edges;
	line_idx_t             step_count;
	req_size_t             size_r;
	line_idx_t             offset_r;
	line_idx_t             count_r;

	//////////////////////////////////////////////////
	// vertex acceptance
	//////////////////////////////////////////////////

	// a job still held with the id just taken is not taken twice
	assign new_job    = vertex_valid && (!have_last || (vertex_id != last_id)) && issue_ok;
	assign vertex_pop = (state == ST_ACCEPT) && new_job;

	//////////////////////////////////////////////////
	// step FSM
	//////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			ST_ACCEPT: begin
				if (vertex_pop) begin
					next_state = ST_INIT;
				end
			end
			ST_INIT: begin
				next_state = (remaining != '0) ? ST_WAIT : ST_ACCEPT;
			end
			ST_WAIT: begin
				if (issue_ok) begin
					next_state = ST_CALC;
				end
			end
			ST_CALC:   next_state = ST_IDLE;
			ST_IDLE:   next_state = ST_SRC;
			ST_SRC:    next_state = ST_DEST;
			ST_DEST:   next_state = ST_WEIGHT;
			ST_WEIGHT: begin
				next_state = (remaining != '0) ? ST_WAIT : ST_ACCEPT;
			end
			default:   next_state = ST_ACCEPT;
		endcase
	end

	// edges this step can carry, up to the line end
	always_comb begin
		span_edges = line_idx_t'(`CACHELINE_EDGES) - rem_edges;
		if (remaining >= edge_count_t'(span_edges)) begin
			step_count = span_edges;
		end else begin
			step_count = line_idx_t'(remaining);
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state      <= ST_ACCEPT;
			remaining  <= '0;
			cur_degree <= '0;
			last_id    <= '0;
			have_last  <= 1'b0;
		end else begin
			state <= next_state;
			if (vertex_pop) begin
				remaining  <= vertex_degree;
				cur_degree <= vertex_degree;
				last_id    <= vertex_id;
				have_last  <= 1'b1;
			end else if (state == ST_CALC) begin
				remaining <= remaining - edge_count_t'(step_count);
			end
		end
	end

	//////////////////////////////////////////////////
	// request sizing
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (vertex_pop) begin
			byte_off <= {{PAD_BITS{1'b0}}, vertex_edges_idx} << EDGE_SHIFT;
		end else if (state == ST_WEIGHT) begin
			// next step starts on the following line
			byte_off <= aligned + `ADDR_BITS'(`CACHELINE_BYTES);
		end
		if (state == ST_WAIT) begin
			aligned   <= {byte_off[`ADDR_BITS-1:LINE_BITS], {LINE_BITS{1'b0}}};
			rem_edges <= line_idx_t'(byte_off[LINE_BITS-1:EDGE_SHIFT]);
		end
		if (state == ST_CALC) begin
			count_r  <= step_count;
			offset_r <= rem_edges;
			// misaligned start pulls the whole line
			if (rem_edges != '0) begin
				size_r <= req_size_t'(`CACHELINE_BYTES);
			end else begin
				size_r <= request_size(step_count);
			end
		end
	end

	//////////////////////////////////////////////////
	// command issue
	//////////////////////////////////////////////////

	always_comb begin
		case (state)
			ST_DEST: begin
				cmd_array = DEST;
				base      = dest_base;
			end
			ST_WEIGHT: begin
				cmd_array = WEIGHT;
				base      = weight_base;
			end
			default: begin
				cmd_array = SRC;
				base      = src_base;
			end
		endcase
	end

	assign cmd_push    = (state == ST_SRC) || (state == ST_DEST) || (state == ST_WEIGHT);
	assign cmd_address = base + aligned;
	assign cmd_size    = size_r;
	assign cmd_offset  = offset_r;
	assign cmd_count   = count_r;

endmodule

/* logic/cacheline_edge_stream.sv */
`timescale 1ns/1ps

`include "edge_defines.svh"

module cacheline_edge_stream (
	input  logic                        clock,
	input  logic                        rstn,
	input  mem_cmd_pkg::array_sel_t     array,
	input  logic                        resp_valid,
	input  mem_cmd_pkg::array_sel_t     resp_array,
	input  mem_cmd_pkg::line_idx_t      resp_offset,
	input  mem_cmd_pkg::line_idx_t      resp_count,
	input  logic [`CACHELINE_BITS-1:0]  resp_data,
	input  logic                        start_shift,
	output logic                        pending,
	output logic                        edge_out_valid,
	output edge_job_pkg::edge_t         edge_out
);

	import mem_cmd_pkg::*;

	localparam int IDX_BITS = $clog2(`CACHELINE_EDGES);

	logic [`CACHELINE_BITS-1:0] line;
	line_idx_t                  offset;
	line_idx_t                  count;
	logic                       load;
	logic                       shift;

	// only the line tagged with this array is taken
	assign load  = resp_valid && (resp_array == array);
	assign shift = start_shift && pending;

	always_ff @(posedge clock) begin
		if (load) begin
			line <= resp_data;
		end
	end

	//////////////////////////////////////////////////
	// edge walk
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pending <= 1'b0;
			offset  <= '0;
			count   <= '0;
		end else if (load) begin
			pending <= 1'b1;
			offset  <= resp_offset;
			count   <= resp_count;
		end else if (shift) begin
			offset <= offset + 1'b1;
			count  <= count - 1'b1;
			// last edge leaves this cycle
			if (count == line_idx_t'(1)) begin
				pending <= 1'b0;
			end
		end
	end

	assign edge_out_valid = shift;
	assign edge_out       = line[offset[IDX_BITS-1:0] * `EDGE_BITS +: `EDGE_BITS];

endmodule

/* logic/edge_job_control.sv */
`timescale 1ns/1ps

`include "edge_defines.svh"

module edge_job_control (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        vertex_valid,
	input  edge_job_pkg::edge_count_t   vertex_id,
	input  edge_job_pkg::edge_count_t   vertex_edges_idx,
	input  edge_job_pkg::edge_count_t   vertex_degree,
	output logic                        vertex_pop,
	input  logic [`ADDR_BITS-1:0]       src_base,
	input  logic [`ADDR_BITS-1:0]       dest_base,
	input  logic [`ADDR_BITS-1:0]       weight_base,
	output logic                        cmd_valid,
	output logic [`ADDR_BITS-1:0]       cmd_address,
	output mem_cmd_pkg::req_size_t      cmd_size,
	output mem_cmd_pkg::array_sel_t     cmd_array,
	output mem_cmd_pkg::line_idx_t      cmd_offset,
	output mem_cmd_pkg::line_idx_t      cmd_count,
	input  logic                        cmd_pop,
	input  logic                        resp_valid,
	input  mem_cmd_pkg::array_sel_t     resp_array,
	input  mem_cmd_pkg::line_idx_t      resp_offset,
	input  mem_cmd_pkg::line_idx_t      resp_count,
	input  logic [`CACHELINE_BITS-1:0]  resp_data,
	output logic                        edge_valid,
	output edge_job_pkg::edge_count_t   edge_id,
	output edge_job_pkg::edge_t         edge_src,
	output edge_job_pkg::edge_t         edge_dest,
	output edge_job_pkg::edge_t         edge_weight,
	input  logic                        edge_pop,
	output edge_job_pkg::edge_count_t   edge_pushed_count
);

	import mem_cmd_pkg::*;
	import edge_job_pkg::*;

	localparam int CMD_WIDTH = `ADDR_BITS + $bits(req_size_t) + $bits(array_sel_t)
		+ 2 * $bits(line_idx_t);
	localparam int EDGE_WIDTH = $bits(edge_count_t) + 3 * $bits(edge_t);
	localparam int FREE_BITS  = $clog2(`EDGE_FIFO_DEPTH + 1);

	logic                         issue_ok;
	logic                         gen_push;
	logic [`ADDR_BITS-1:0]        gen_address;
	req_size_t                    gen_size;
	array_sel_t                   gen_array;
	line_idx_t                    gen_offset;
	line_idx_t                    gen_count;
	edge_count_t                  cur_degree;
	logic [CMD_WIDTH-1:0]         cmd_in;
	logic [CMD_WIDTH-1:0]         cmd_out;
	logic [$bits(array_sel_t)-1:0] cmd_array_bits;
	logic                         cmd_empty;
	logic [2:0]                   outstanding;
	logic                         src_pending;
	logic                         dest_pending;
	logic                         weight_pending;
	logic                         src_ev;
	logic                         dest_ev;
	logic                         weight_ev;
	edge_t                        src_edge;
	edge_t                        dest_edge;
	edge_t                        weight_edge;
	logic                         start_shift;
	logic                         edge_push;
	edge_count_t                  edge_id_cnt;
	logic [EDGE_WIDTH-1:0]        edge_in;
	logic [EDGE_WIDTH-1:0]        edge_out;
	logic [FREE_BITS-1:0]         edge_free;

	//////////////////////////////////////////////////
	// read command generation
	//////////////////////////////////////////////////

	// idle everywhere and one full line of room left
	assign issue_ok = cmd_empty && (outstanding == '0)
		&& !(src_pending || dest_pending || weight_pending)
		&& (edge_free >= FREE_BITS'(`CACHELINE_EDGES));

	edge_read_cmd_gen u_cmd_gen (
		.clock            (clock),
		.rstn             (rstn),
		.vertex_valid     (vertex_valid),
		.vertex_id        (vertex_id),
		.vertex_edges_idx (vertex_edges_idx),
		.vertex_degree    (vertex_degree),
		.vertex_pop       (vertex_pop),
		.src_base         (src_base),
		.dest_base        (dest_base),
		.weight_base      (weight_base),
		.issue_ok         (issue_ok),
		.cmd_push         (gen_push),
		.cmd_address      (gen_address),
		.cmd_size         (gen_size),
		.cmd_array        (gen_array),
		.cmd_offset       (gen_offset),
		.cmd_count        (gen_count),
		.cur_degree       (cur_degree)
	);

	assign cmd_in = {gen_address, gen_size, gen_array, gen_offset, gen_count};

	sync_fifo #(
		.WIDTH (CMD_WIDTH),
		.DEPTH (`CMD_FIFO_DEPTH)
	) u_cmd_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (gen_push),
		.data_in    (cmd_in),
		.full       (),
		.free_slots (),
		.pop        (cmd_pop),
		.valid      (cmd_valid),
		.data_out   (cmd_out),
		.empty      (cmd_empty)
	);

	assign {cmd_address, cmd_size, cmd_array_bits, cmd_offset, cmd_count} = cmd_out;
	assign cmd_array = array_sel_t'(cmd_array_bits);

	// up per command pushed, down per response
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= '0;
		end else begin
			outstanding <= outstanding + {2'b00, gen_push} - {2'b00, resp_valid};
		end
	end

	//////////////////////////////////////////////////
	// cacheline streams
	//////////////////////////////////////////////////

	assign start_shift = src_pending && dest_pending && weight_pending && (outstanding == '0);

	cacheline_edge_stream u_src_stream (
		.clock          (clock),
		.rstn           (rstn),
		.array          (SRC),
		.resp_valid     (resp_valid),
		.resp_array     (resp_array),
		.resp_offset    (resp_offset),
		.resp_count     (resp_count),
		.resp_data      (resp_data),
		.start_shift    (start_shift),
		.pending        (src_pending),
		.edge_out_valid (src_ev),
		.edge_out       (src_edge)
	);

	cacheline_edge_stream u_dest_stream (
		.clock          (clock),
		.rstn           (rstn),
		.array          (DEST),
		.resp_valid     (resp_valid),
		.resp_array     (resp_array),
		.resp_offset    (resp_offset),
		.resp_count     (resp_count),
		.resp_data      (resp_data),
		.start_shift    (start_shift),
		.pending        (dest_pending),
		.edge_out_valid (dest_ev),
		.edge_out       (dest_edge)
	);

	cacheline_edge_stream u_weight_stream (
		.clock          (clock),
		.rstn           (rstn),
		.array          (WEIGHT),
		.resp_valid     (resp_valid),
		.resp_array     (resp_array),
		.resp_offset    (resp_offset),
		.resp_count     (resp_count),
		.resp_data      (resp_data),
		.start_shift    (start_shift),
		.pending        (weight_pending),
		.edge_out_valid (weight_ev),
		.edge_out       (weight_edge)
	);

	//////////////////////////////////////////////////
	// edge assembly
	//////////////////////////////////////////////////

	assign edge_push = src_ev && dest_ev && weight_ev;
	assign edge_in   = {edge_id_cnt, swap_edge_bytes(src_edge), swap_edge_bytes(dest_edge),
		swap_edge_bytes(weight_edge)};

	// ids run on across vertices, pushed count restarts per vertex
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_id_cnt       <= '0;
			edge_pushed_count <= '0;
		end else if (edge_push) begin
			edge_id_cnt <= edge_id_cnt + 1'b1;
			if (edge_pushed_count + 1'b1 == cur_degree) begin
				edge_pushed_count <= '0;
			end else begin
				edge_pushed_count <= edge_pushed_count + 1'b1;
			end
		end
	end

	sync_fifo #(
		.WIDTH (EDGE_WIDTH),
		.DEPTH (`EDGE_FIFO_DEPTH)
	) u_edge_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (edge_push),
		.data_in    (edge_in),
		.full       (),
		.free_slots (edge_free),
		.pop        (edge_pop),
		.valid      (edge_valid),
		.data_out   (edge_out),
		.empty      ()
	);

	assign {edge_id, edge_src, edge_dest, edge_weight} = edge_out;

endmodule

/* test/edge_job_control_tb.sv */
`timescale 1ns/1ps

`include "edge_defines.svh"

module edge_job_control_tb;

	import mem_cmd_pkg::*;

	localparam int TRACE_WORDS = 192;
	localparam int MEM_EDGES   = 256;
	localparam int WAIT_LIMIT  = 4000;

	logic                        clock;
	logic                        rstn;
	logic                        vertex_valid;
	logic [31:0]                 vertex_id;
	logic [31:0]                 vertex_edges_idx;
	logic [31:0]                 vertex_degree;
	logic                        vertex_pop;
	logic [`ADDR_BITS-1:0]       src_base;
	logic [`ADDR_BITS-1:0]       dest_base;
	logic [`ADDR_BITS-1:0]       weight_base;
	logic                        cmd_valid;
	logic [`ADDR_BITS-1:0]       cmd_address;
	logic [7:0]                  cmd_size;
	array_sel_t                  cmd_array;
	logic [5:0]                  cmd_offset;
	logic [5:0]                  cmd_count;
	logic                        cmd_pop;
	logic                        resp_valid;
	array_sel_t                  resp_array;
	logic [5:0]                  resp_offset;
	logic [5:0]                  resp_count;
	logic [`CACHELINE_BITS-1:0]  resp_data;
	logic                        edge_valid;
	logic [31:0]                 edge_id;
	logic [31:0]                 edge_src;
	logic [31:0]                 edge_dest;
	logic [31:0]                 edge_weight;
	logic                        edge_pop;
	logic [31:0]                 edge_pushed_count;

	// trace contents and memory model
	logic [63:0] trace [TRACE_WORDS];
	logic [63:0] base_addr [3];
	logic [31:0] mem_words [3*MEM_EDGES];
	logic [31:0] vid_q [$];
	logic [31:0] vidx_q [$];
	logic [31:0] vdeg_q [$];
	logic [31:0] deg_q [$];
	logic [63:0] cmd_line_q [$];
	logic [63:0] cmd_size_q [$];
	logic [63:0] cmd_offset_q [$];
	logic [63:0] cmd_count_q [$];
	logic [31:0] exp_id_q [$];
	logic [31:0] exp_src_q [$];
	logic [31:0] exp_dest_q [$];
	logic [31:0] exp_weight_q [$];

	int          checks;
	int          value_errors;
	int          failures;
	int          pushes_seen;
	int          deg_idx;
	int unsigned seed_dummy;
	logic        aborted;
	logic        monitor_on;
	logic [31:0] seen_count;
	logic [31:0] model_count;
	logic [31:0] next_count;

	edge_job_control uut (
		.clock             (clock),
		.rstn              (rstn),
		.vertex_valid      (vertex_valid),
		.vertex_id         (vertex_id),
		.vertex_edges_idx  (vertex_edges_idx),
		.vertex_degree     (vertex_degree),
		.vertex_pop        (vertex_pop),
		.src_base          (src_base),
		.dest_base         (dest_base),
		.weight_base       (weight_base),
		.cmd_valid         (cmd_valid),
		.cmd_address       (cmd_address),
		.cmd_size          (cmd_size),
		.cmd_array         (cmd_array),
		.cmd_offset        (cmd_offset),
		.cmd_count         (cmd_count),
		.cmd_pop           (cmd_pop),
		.resp_valid        (resp_valid),
		.resp_array        (resp_array),
		.resp_offset       (resp_offset),
		.resp_count        (resp_count),
		.resp_data         (resp_data),
		.edge_valid        (edge_valid),
		.edge_id           (edge_id),
		.edge_src          (edge_src),
		.edge_dest         (edge_dest),
		.edge_weight       (edge_weight),
		.edge_pop          (edge_pop),
		.edge_pushed_count (edge_pushed_count)
	);

	always #10 clock = ~clock;

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("ERROR %s: got %0h, expected %0h", name, actual, expected);
			value_errors++;
		end
	endtask

	// words outside the trace get a value built from the full byte address
	function automatic logic [31:0] fill_word(input logic [63:0] addr);
		return addr[31:0] ^ addr[63:32] ^ 32'h5a5a_a5a5;
	endfunction

	task automatic fill_memory();
		logic [63:0] addr;
		for (int a = 0; a < 3; a++) begin
			for (int i = 0; i < MEM_EDGES; i++) begin
				addr = base_addr[a] + 64'(4 * i);
				mem_words[a*MEM_EDGES + i] = fill_word(addr);
			end
		end
	endtask

	function automatic logic [`CACHELINE_BITS-1:0] build_line(input int arr,
		input logic [63:0] addr);
		logic [`CACHELINE_BITS-1:0] line;
		logic [63:0]                idx;
		line = '0;
		for (int k = 0; k < `CACHELINE_EDGES; k++) begin
			idx = ((addr - base_addr[arr]) >> 2) + 64'(k);
			if (idx < MEM_EDGES) begin
				line[k*`EDGE_BITS +: `EDGE_BITS] = mem_words[arr*MEM_EDGES + int'(idx)];
			end else begin
				line[k*`EDGE_BITS +: `EDGE_BITS] = fill_word(addr + 64'(4 * k));
			end
		end
		return line;
	endfunction

	task automatic load_trace();
		int          p;
		logic [63:0] first;
		logic [63:0] n;
		logic [31:0] word;
		for (int i = 0; i < TRACE_WORDS; i++) begin
			trace[i] = '0;
		end
		$readmemh("test/edge_trace.txt", trace);
		p = 0;
		while (p + 6 <= TRACE_WORDS && trace[p] != '0) begin
			first = trace[p+1];
			n     = trace[p+2];
			case (trace[p])
				64'd1: begin
					for (int a = 0; a < 3; a++) begin
						base_addr[a] = trace[p+1+a];
					end
					fill_memory();
				end
				64'd2: begin
					// top byte of each memory word counts up per edge
					for (int i = 0; i < n; i++) begin
						for (int a = 0; a < 3; a++) begin
							if (first + 64'(i) < MEM_EDGES) begin
								word = trace[p+3+a][31:0] + (i << 24);
								mem_words[a*MEM_EDGES + int'(first) + i] = word;
							end
						end
					end
				end
				64'd3: begin
					vid_q.push_back(trace[p+1][31:0]);
					vidx_q.push_back(trace[p+2][31:0]);
					vdeg_q.push_back(trace[p+3][31:0]);
					if (trace[p+3] != '0) begin
						deg_q.push_back(trace[p+3][31:0]);
					end
				end
				64'd4: begin
					cmd_line_q.push_back(trace[p+1]);
					cmd_size_q.push_back(trace[p+2]);
					cmd_offset_q.push_back(trace[p+3]);
					cmd_count_q.push_back(trace[p+4]);
				end
				64'd5: begin
					for (int i = 0; i < n; i++) begin
						word = first[31:0] + i;
						exp_id_q.push_back(word);
						word = trace[p+3][31:0] + i;
						exp_src_q.push_back(word);
						word = trace[p+4][31:0] + i;
						exp_dest_q.push_back(word);
						word = trace[p+5][31:0] + i;
						exp_weight_q.push_back(word);
					end
				end
				default: begin
					$display("trace record %0d has unknown kind %0h", p / 6, trace[p]);
					failures++;
				end
			endcase
			p = p + 6;
		end
	endtask

	//////////////////////////////////////////////////
	// vertex driver, memory responder, edge consumer
	//////////////////////////////////////////////////

	task automatic drive_vertices();
		int waited;
		for (int v = 0; v < vid_q.size(); v++) begin
			vertex_valid     <= 1'b1;
			vertex_id        <= vid_q[v];
			vertex_edges_idx <= vidx_q[v];
			vertex_degree    <= vdeg_q[v];
			waited = 0;
			@(posedge clock);
			while (!vertex_pop && !aborted && waited < WAIT_LIMIT) begin
				@(posedge clock);
				waited++;
			end
			if (aborted) begin
				vertex_valid <= 1'b0;
				return;
			end
			if (!vertex_pop) begin
				$display("timeout: vertex job %0h was never accepted", vid_q[v]);
				failures++;
				aborted = 1'b1;
				vertex_valid <= 1'b0;
				return;
			end
		end
		vertex_valid <= 1'b0;
	endtask

	task automatic serve_commands();
		int          waited;
		int          delay;
		logic [63:0] addr;
		logic [5:0]  off;
		logic [5:0]  cnt;
		for (int c = 0; c < cmd_line_q.size(); c++) begin
			// each step reads SRC, DEST, WEIGHT in turn
			for (int a = 0; a < 3; a++) begin
				waited = 0;
				@(posedge clock);
				while (!cmd_valid && !aborted && waited < WAIT_LIMIT) begin
					@(posedge clock);
					waited++;
				end
				if (aborted) begin
					return;
				end
				if (!cmd_valid) begin
					$display("timeout: read command %0d of step %0d never appeared", a, c);
					failures++;
					aborted = 1'b1;
					return;
				end
				addr = cmd_address;
				off  = cmd_offset;
				cnt  = cmd_count;
				check_value("cmd_array", cmd_array, a);
				check_value("cmd_address", cmd_address, base_addr[a] + cmd_line_q[c]);
				check_value("cmd_size", cmd_size, cmd_size_q[c]);
				check_value("cmd_offset", cmd_offset, cmd_offset_q[c]);
				check_value("cmd_count", cmd_count, cmd_count_q[c]);
				cmd_pop <= 1'b1;
				@(posedge clock);
				cmd_pop <= 1'b0;
				delay = $urandom % 4;
				repeat (delay) @(posedge clock);
				resp_valid  <= 1'b1;
				resp_array  <= array_sel_t'(a);
				resp_offset <= off;
				resp_count  <= cnt;
				resp_data   <= build_line(a, addr);
				@(posedge clock);
				resp_valid <= 1'b0;
			end
		end
	endtask

	task automatic consume_edges();
		int waited;
		int stall;
		for (int i = 0; i < exp_id_q.size(); i++) begin
			stall = $urandom % 3;
			repeat (stall) @(posedge clock);
			waited = 0;
			@(posedge clock);
			while (!edge_valid && !aborted && waited < WAIT_LIMIT) begin
				@(posedge clock);
				waited++;
			end
			if (aborted) begin
				return;
			end
			if (!edge_valid) begin
				$display("timeout: expected edge %0d never reached the edge output", i);
				failures++;
				aborted = 1'b1;
				return;
			end
			check_value("edge_id", edge_id, exp_id_q[i]);
			check_value("edge_src", edge_src, exp_src_q[i]);
			check_value("edge_dest", edge_dest, exp_dest_q[i]);
			check_value("edge_weight", edge_weight, exp_weight_q[i]);
			edge_pop <= 1'b1;
			@(posedge clock);
			edge_pop <= 1'b0;
		end
	endtask

	// a change of the pushed count marks one push and the model wraps at each degree
	always @(posedge clock) begin
		if (rstn && monitor_on && (edge_pushed_count !== seen_count)) begin
			if (deg_idx < deg_q.size()) begin
				next_count = (model_count + 1 == deg_q[deg_idx]) ? '0 : model_count + 1;
				check_value("edge_pushed_count", edge_pushed_count, next_count);
				model_count = next_count;
				if (next_count == '0) begin
					deg_idx++;
				end
			end else begin
				$display("edge pushed count moved after the last vertex was done");
				failures++;
			end
			pushes_seen++;
			seen_count = edge_pushed_count;
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		clock            = 1'b0;
		rstn             = 1'b0;
		vertex_valid     = 1'b0;
		vertex_id        = '0;
		vertex_edges_idx = '0;
		vertex_degree    = '0;
		cmd_pop          = 1'b0;
		resp_valid       = 1'b0;
		resp_array       = SRC;
		resp_offset      = '0;
		resp_count       = '0;
		resp_data        = '0;
		edge_pop         = 1'b0;
		checks           = 0;
		value_errors     = 0;
		failures         = 0;
		pushes_seen      = 0;
		deg_idx          = 0;
		aborted          = 1'b0;
		monitor_on       = 1'b0;
		seen_count       = '0;
		model_count      = '0;
		seed_dummy       = $urandom(38);
		base_addr[0]     = '0;
		base_addr[1]     = '0;
		base_addr[2]     = '0;
		load_trace();
		src_base    = base_addr[0];
		dest_base   = base_addr[1];
		weight_base = base_addr[2];
		if (vid_q.size() == 0 || exp_id_q.size() == 0) begin
			$display("trace file gave no vertex jobs or no expected edges");
			failures++;
		end

		repeat (8) @(posedge clock);
		check_value("vertex_pop", vertex_pop, 0);
		check_value("cmd_valid", cmd_valid, 0);
		check_value("edge_valid", edge_valid, 0);
		rstn <= 1'b1;
		// idle outputs right after reset
		repeat (3) begin
			@(posedge clock);
			check_value("vertex_pop", vertex_pop, 0);
			check_value("cmd_valid", cmd_valid, 0);
			check_value("edge_valid", edge_valid, 0);
			check_value("edge_pushed_count", edge_pushed_count, 0);
		end
		monitor_on = 1'b1;

		fork
			drive_vertices();
			serve_commands();
			consume_edges();
		join

		repeat (4) @(posedge clock);
		monitor_on = 1'b0;
		check_value("cmd_valid", cmd_valid, 0);
		check_value("edge_valid", edge_valid, 0);
		check_value("edge_pushed_count", edge_pushed_count, 0);
		check_value("edges pushed", pushes_seen, exp_id_q.size());

		$display("checks %0d, value errors %0d, other failures %0d",
			checks, value_errors, failures);
		if (value_errors == 0 && failures == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+include
logic/mem_cmd_pkg.sv
logic/edge_job_pkg.sv
logic/sync_fifo.sv
logic/edge_read_cmd_gen.sv
logic/cacheline_edge_stream.sv
logic/edge_job_control.sv
test/edge_job_control_tb.sv

/* Bender.yml */
package:
  name: edge_job_control

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/mem_cmd_pkg.sv
      - logic/edge_job_pkg.sv
      - logic/sync_fifo.sv
      - logic/edge_read_cmd_gen.sv
      - logic/cacheline_edge_stream.sv
      - logic/edge_job_control.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/edge_job_control_tb.sv

/* test/edge_trace.txt */
// one record per line: kind, then five hex fields (unused fields are 0)
// 1 bases: src dest weight | 2 memory: first_edge count src_word dest_word weight_word
// 3 vertex: id edges_idx degree | 4 step: line_offset size offset count, for SRC DEST WEIGHT
// 5 edges: first_id count src dest weight | 0 end of trace
// memory words grow by 01000000 per edge, expected edge fields grow by 1
1 1000000000 2000000000 3000000000 0 0
2 0 40 00112233 00445566 00778899
2 4a 1c 00a1b2c3 00d4e5f6 00135724
2 80 3 00246801 00369c02 0048ad03
2 a5 25 0059be04 006acf05 007bd006
// aligned, misaligned with short tail, zero degree, short aligned, misaligned
3 1 0 40 0 0
3 2 4a 1c 0 0
3 3 90 0 0 0
3 4 80 3 0 0
3 5 a5 25 0 0
4 0 80 0 20 0
4 80 80 0 20 0
4 100 80 a 16 0
4 180 20 0 6 0
4 200 10 0 3 0
4 280 80 5 1b 0
4 300 40 0 a 0
5 0 40 33221100 66554400 99887700
5 40 1c c3b2a100 f6e5d400 24571300
5 5c 3 01682400 029c3600 03ad4800
5 5f 25 04be5900 05cf6a00 06d07b00
0 0 0 0 0 0
